// File: include/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Bits handled per clock, one of 1, 2, 4 or 8
`define SERIAL_W 4

// Count cycles needed to walk a 32-bit word
`define SERIAL_STEPS (32 / `SERIAL_W)

// Operation code width
`define OP_BITS 4

`endif

// File: rtl/exec_ctrl_pkg.sv
`include "exec_cfg.svh"

package exec_ctrl_pkg;

   // One slice of a 32-bit operand
   typedef logic [`SERIAL_W-1:0] chunk_t;

   // Strobes from the step controller
   typedef struct packed {
      // Operand capture cycle
      logic load;
      // Count cycle active
      logic en;
      // Final count cycle
      logic last;
   } step_t;

endpackage

// File: rtl/exec_op_pkg.sv
`include "exec_cfg.svh"

package exec_op_pkg;

   // Operation set of the serial datapath
   typedef enum logic [`OP_BITS-1:0] {
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_SLT,
      OP_SLTU,
      OP_SLL,
      OP_SRL,
      OP_SRA
   } op_e;

   // Request payload, held stable while req is high
   typedef struct packed {
      op_e         op;
      logic [31:0] rs1;
      logic [31:0] rs2;
   } exec_cmd_t;

   typedef struct packed {
      logic [31:0] result;
   } exec_rsp_t;

endpackage

// File: rtl/result_collect.sv
`include "exec_cfg.svh"

module result_collect (
   input  logic                   clk,
   input  logic                   i_arst_n,
   input  exec_op_pkg::exec_cmd_t i_cmd,
   input  exec_ctrl_pkg::step_t   i_step,
   input  exec_ctrl_pkg::chunk_t  i_alu_chunk,
   input  exec_ctrl_pkg::chunk_t  i_shift_chunk,
   input  logic                   i_cmp,
   output exec_op_pkg::exec_rsp_t o_rsp
);

   logic [31:0]           result_q;
   logic                  shift_op;
   logic                  slt_op;
   exec_ctrl_pkg::chunk_t chunk;

   assign shift_op = (i_cmd.op == exec_op_pkg::OP_SLL)
                  || (i_cmd.op == exec_op_pkg::OP_SRL)
                  || (i_cmd.op == exec_op_pkg::OP_SRA);
   assign slt_op   = (i_cmd.op == exec_op_pkg::OP_SLT)
                  || (i_cmd.op == exec_op_pkg::OP_SLTU);

   assign chunk = shift_op ? i_shift_chunk : i_alu_chunk;

   // Chunks enter at the top and drift down, LSB chunk ends at bit 0
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         result_q <= '0;
      end else if (i_step.en) begin
         if (i_step.last && slt_op) begin
            result_q <= {31'd0, i_cmp};
         end else begin
            result_q <= {chunk, result_q[31:`SERIAL_W]};
         end
      end
   end

   // Held until the next operation starts counting
   assign o_rsp.result = result_q;

endmodule

// File: rtl/serial_alu.sv
`include "exec_cfg.svh"

module serial_alu (
   input  logic                     clk,
   input  logic                     i_arst_n,
   input  exec_op_pkg::exec_cmd_t   i_cmd,
   input  exec_ctrl_pkg::step_t     i_step,
   output exec_ctrl_pkg::chunk_t    o_chunk,
   output logic                     o_cmp
);

   logic [31:0]           rs1_q;
   logic [31:0]           rs2_q;
   logic                  carry_q;

   exec_ctrl_pkg::chunk_t op_a;
   exec_ctrl_pkg::chunk_t op_b;
   exec_ctrl_pkg::chunk_t op_b_eff;
   exec_ctrl_pkg::chunk_t sum;
   logic                  carry_out;
   logic                  sub;
   logic                  cmp_sig;
   logic                  a_top;
   logic                  b_top;

   // Compares reuse the subtract path
   assign sub = (i_cmd.op == exec_op_pkg::OP_SUB)
             || (i_cmd.op == exec_op_pkg::OP_SLT)
             || (i_cmd.op == exec_op_pkg::OP_SLTU);
   assign cmp_sig = (i_cmd.op == exec_op_pkg::OP_SLT);

   assign op_a     = rs1_q[`SERIAL_W-1:0];
   assign op_b     = rs2_q[`SERIAL_W-1:0];
   assign op_b_eff = sub ? ~op_b : op_b;

   assign {carry_out, sum} = {1'b0, op_a} + {1'b0, op_b_eff}
                           + {{`SERIAL_W{1'b0}}, carry_q};

   // Operands walk toward bit 0 one chunk per count cycle
   always_ff @(posedge clk) begin
      if (i_step.load) begin
         rs1_q <= i_cmd.rs1;
         rs2_q <= i_cmd.rs2;
      end else if (i_step.en) begin
         rs1_q <= rs1_q >> `SERIAL_W;
         rs2_q <= rs2_q >> `SERIAL_W;
      end
   end

   // Carry seeded with one for two's complement subtract
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         carry_q <= 1'b0;
      end else if (i_step.load) begin
         carry_q <= sub;
      end else if (i_step.en) begin
         carry_q <= carry_out;
      end
   end

   always_comb begin
      case (i_cmd.op)
         exec_op_pkg::OP_AND: o_chunk = op_a & op_b;
         exec_op_pkg::OP_OR:  o_chunk = op_a | op_b;
         exec_op_pkg::OP_XOR: o_chunk = op_a ^ op_b;
         default:             o_chunk = sum;
      endcase
   end

   // Sign bits sit in the top of the last chunk
   assign a_top = op_a[`SERIAL_W-1];
   assign b_top = op_b[`SERIAL_W-1];

   // No carry out of rs1 - rs2 means a borrow, so rs1 is below rs2
   always_comb begin
      if (cmp_sig && (a_top != b_top)) begin
         o_cmp = a_top;
      end else begin
         o_cmp = ~carry_out;
      end
   end

endmodule

// File: rtl/serial_exec_top.sv
module serial_exec_top (
   input  logic                   clk,
   input  logic                   i_arst_n,
   input  logic                   i_req,
   input  exec_op_pkg::exec_cmd_t i_cmd,
   output logic                   o_ack,
   output exec_op_pkg::exec_rsp_t o_rsp
);

   exec_ctrl_pkg::step_t  step;
   exec_ctrl_pkg::chunk_t alu_chunk;
   exec_ctrl_pkg::chunk_t shift_chunk;
   logic                  alu_cmp;

   serial_state u_state (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_req    (i_req),
      .o_ack    (o_ack),
      .o_step   (step)
   );

   serial_alu u_alu (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_cmd    (i_cmd),
      .i_step   (step),
      .o_chunk  (alu_chunk),
      .o_cmp    (alu_cmp)
   );

   serial_shifter u_shift (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_cmd    (i_cmd),
      .i_step   (step),
      .o_chunk  (shift_chunk)
   );

   // Final merge of both datapaths
   result_collect u_collect (
      .clk           (clk),
      .i_arst_n      (i_arst_n),
      .i_cmd         (i_cmd),
      .i_step        (step),
      .i_alu_chunk   (alu_chunk),
      .i_shift_chunk (shift_chunk),
      .i_cmp         (alu_cmp),
      .o_rsp         (o_rsp)
   );

endmodule

// File: rtl/serial_shifter.sv
`include "exec_cfg.svh"

module serial_shifter (
   input  logic                   clk,
   input  logic                   i_arst_n,
   input  exec_op_pkg::exec_cmd_t i_cmd,
   input  exec_ctrl_pkg::step_t   i_step,
   output exec_ctrl_pkg::chunk_t  o_chunk
);

   localparam int CNT_W = $clog2(`SERIAL_STEPS);

   logic [31:0]      word_q;
   logic [4:0]       shamt_q;
   logic [CNT_W-1:0] idx_q;
   logic             sh_left;
   logic             fill;

   assign sh_left = (i_cmd.op == exec_op_pkg::OP_SLL);
   assign fill    = (i_cmd.op == exec_op_pkg::OP_SRA) && word_q[31];

   always_ff @(posedge clk) begin
      if (i_step.load) begin
         word_q  <= i_cmd.rs1;
         shamt_q <= i_cmd.rs2[4:0];
      end
   end

   // Chunk index, the word itself stays put
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         idx_q <= '0;
      end else if (i_step.load) begin
         idx_q <= '0;
      end else if (i_step.en) begin
         idx_q <= idx_q + 1'b1;
      end
   end

   // Pick each output bit straight from the stored word
   always_comb begin
      logic [6:0] base;
      logic [6:0] pos;
      logic [6:0] src;
      base = 7'(idx_q) * 7'(`SERIAL_W);
      for (int j = 0; j < `SERIAL_W; j++) begin
         pos = base + 7'(j);
         if (sh_left) begin
            src        = pos - 7'(shamt_q);
            o_chunk[j] = (pos >= 7'(shamt_q)) ? word_q[src[4:0]] : 1'b0;
         end else begin
            src        = pos + 7'(shamt_q);
            o_chunk[j] = (src < 7'd32) ? word_q[src[4:0]] : fill;
         end
      end
   end

endmodule

// File: rtl/serial_state.sv
`include "exec_cfg.svh"

module serial_state (
   input  logic                 clk,
   input  logic                 i_arst_n,
   input  logic                 i_req,
   output logic                 o_ack,
   output exec_ctrl_pkg::step_t o_step
);

   localparam int CNT_W = $clog2(`SERIAL_STEPS);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SERIAL_STEPS - 1);

   typedef enum logic [2:0] {
      S_IDLE,
      S_LOAD,
      S_COUNT,
      S_ACK,
      S_WAIT_LOW
   } state_e;

   state_e           state_q;
   logic [CNT_W-1:0] cnt_q;
   logic             cnt_done;

   assign cnt_done = (cnt_q == CNT_LAST);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state_q <= S_IDLE;
         cnt_q   <= '0;
         o_ack   <= 1'b0;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (i_req) begin
                  state_q <= S_LOAD;
               end
            end
            S_LOAD: begin
               cnt_q   <= '0;
               state_q <= S_COUNT;
            end
            S_COUNT: begin
               cnt_q <= cnt_q + 1'b1;
               if (cnt_done) begin
                  state_q <= S_ACK;
               end
            end
            // Result settled, raise ack on the way out
            S_ACK: begin
               o_ack   <= 1'b1;
               state_q <= S_WAIT_LOW;
            end
            // Hold ack until the requester lets go
            S_WAIT_LOW: begin
               if (!i_req) begin
                  o_ack   <= 1'b0;
                  state_q <= S_IDLE;
               end
            end
            default: begin
               state_q <= S_IDLE;
            end
         endcase
      end
   end

   assign o_step.load = (state_q == S_LOAD);
   assign o_step.en   = (state_q == S_COUNT);
   assign o_step.last = (state_q == S_COUNT) && cnt_done;

endmodule

// File: serial_exec_top.f
+incdir+include
rtl/exec_op_pkg.sv
rtl/exec_ctrl_pkg.sv
rtl/serial_state.sv
rtl/serial_alu.sv
rtl/serial_shifter.sv
rtl/result_collect.sv
rtl/serial_exec_top.sv
verif/tb_serial_exec.sv

// File: verif/tb_serial_exec.sv
`include "exec_cfg.svh"

module tb_serial_exec;

   localparam int RESET_CYCLES = 10;
   localparam int N_RANDOM     = 30;
   localparam int N_CORNERS    = 5;
   localparam int N_OPS        = 10 * N_RANDOM + 10 * N_CORNERS * N_CORNERS;
   localparam int MAX_HOLD     = 5;
   // Each operation takes at most STEPS + 6 cycles plus the extra hold
   localparam int CYCLE_LIMIT  = N_OPS * (`SERIAL_STEPS + 6) + N_OPS * MAX_HOLD
                               + RESET_CYCLES + 200;

   logic                   clk;
   logic                   i_arst_n;
   logic                   i_req;
   exec_op_pkg::exec_cmd_t i_cmd;
   logic                   o_ack;
   exec_op_pkg::exec_rsp_t o_rsp;

   int          errors;
   int          checks;
   int          cycle_cnt;
   logic [31:0] rng;

   serial_exec_top uut (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_req    (i_req),
      .i_cmd    (i_cmd),
      .o_ack    (o_ack),
      .o_rsp    (o_rsp)
   );

   always #20 clk = ~clk;

   // Ends the run if ack never comes
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("Timed out waiting for ack after %0d cycles", cycle_cnt);
         errors = errors + 1;
         $display("Summary: %0d checks, %0d errors", checks, errors);
         $display("Something failed");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // Expected result straight from the operation definitions
   function automatic logic [31:0] model(input exec_op_pkg::op_e op,
                                         input logic [31:0] a,
                                         input logic [31:0] b);
      logic [4:0] sh;
      sh = b[4:0];
      case (op)
         exec_op_pkg::OP_ADD:  return a + b;
         exec_op_pkg::OP_SUB:  return a - b;
         exec_op_pkg::OP_AND:  return a & b;
         exec_op_pkg::OP_OR:   return a | b;
         exec_op_pkg::OP_XOR:  return a ^ b;
         exec_op_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         exec_op_pkg::OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
         exec_op_pkg::OP_SLL:  return a << sh;
         exec_op_pkg::OP_SRL:  return a >> sh;
         exec_op_pkg::OP_SRA:  return $unsigned($signed(a) >>> sh);
         default:              return 32'd0;
      endcase
   endfunction

   function automatic logic [31:0] corner(input int idx);
      case (idx)
         0:       return 32'h0000_0000;
         1:       return 32'hffff_ffff;
         2:       return 32'h8000_0000;
         3:       return 32'h7fff_ffff;
         default: return 32'd31;
      endcase
   endfunction

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string msg);
      checks = checks + 1;
      if (actual !== expected) begin
         errors = errors + 1;
         $display("Mismatch at time %0t: %s, got %h expected %h",
                  $time, msg, actual, expected);
      end
   endtask

   // One full four-phase transaction with a checked result
   task automatic run_op(input exec_op_pkg::op_e op, input logic [31:0] a,
                         input logic [31:0] b, input int hold);
      exec_op_pkg::exec_cmd_t cmd;
      logic [31:0]            exp;
      int                     n;
      string                  ctx;
      cmd.op  = op;
      cmd.rs1 = a;
      cmd.rs2 = b;
      exp     = model(op, a, b);
      ctx     = $sformatf("op %0d rs1 %h rs2 %h", op, a, b);
      n       = 0;
      @(posedge clk);
      i_cmd <= cmd;
      i_req <= 1'b1;
      // First negedge follows the drive edge and the second follows edge 0
      do begin
         @(negedge clk);
         n = n + 1;
      end while (o_ack !== 1'b1);
      check(32'(n - 2), 32'(`SERIAL_STEPS + 2), {ctx, " ack latency"});
      check(o_rsp.result, exp, {ctx, " result"});
      repeat (hold) begin
         @(negedge clk);
         check({31'd0, o_ack}, 32'd1, {ctx, " ack during hold"});
         check(o_rsp.result, exp, {ctx, " rsp during hold"});
      end
      @(posedge clk);
      i_req <= 1'b0;
      @(negedge clk);
      check({31'd0, o_ack}, 32'd1, {ctx, " ack before req seen low"});
      @(negedge clk);
      check({31'd0, o_ack}, 32'd0, {ctx, " ack after req drop"});
      check(o_rsp.result, exp, {ctx, " rsp after handshake"});
   endtask

   initial begin
      int               hold;
      logic [31:0]      a;
      logic [31:0]      b;
      exec_op_pkg::op_e op;
      clk       = 1'b0;
      i_arst_n  = 1'b0;
      i_req     = 1'b0;
      i_cmd     = '0;
      errors    = 0;
      checks    = 0;
      cycle_cnt = 0;
      rng       = 32'd57245;

      repeat (RESET_CYCLES) @(posedge clk);
      i_arst_n <= 1'b1;
      @(negedge clk);
      check({31'd0, o_ack}, 32'd0, "ack after reset");
      check(o_rsp.result, 32'd0, "rsp after reset");

      // Random operands
      for (int op_idx = 0; op_idx < 10; op_idx++) begin
         op = exec_op_pkg::op_e'(op_idx);
         for (int i = 0; i < N_RANDOM; i++) begin
            rng  = xorshift32(rng);
            a    = rng;
            rng  = xorshift32(rng);
            b    = rng;
            rng  = xorshift32(rng);
            hold = int'(rng % (MAX_HOLD + 1));
            run_op(op, a, b, hold);
         end
      end

      // Corner operand pairs including shift amounts 0 and 31
      for (int op_idx = 0; op_idx < 10; op_idx++) begin
         op = exec_op_pkg::op_e'(op_idx);
         for (int i = 0; i < N_CORNERS; i++) begin
            for (int j = 0; j < N_CORNERS; j++) begin
               rng  = xorshift32(rng);
               hold = int'(rng % (MAX_HOLD + 1));
               run_op(op, corner(i), corner(j), hold);
            end
         end
      end

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
